//--- verif/core_testdata.hex
// Words 0-15 program at 0x8000_0000, word 16 expected store count,
// then one "address data" pair per store in bus order, then exit code (a0)
00500093  // addi x1, x0, 5
00700113  // addi x2, x0, 7
002081b3  // add  x3, x1, x2
80000237  // lui  x4, 0x80000
04322023  // sw   x3, 64(x4)
04022283  // lw   x5, 64(x4)
00128333  // add  x6, x5, x1
04622223  // sw   x6, 68(x4)
00208463  // beq  x1, x2, +8 (not taken)
04122423  // sw   x1, 72(x4)
00108463  // beq  x1, x1, +8 (taken)
04222623  // sw   x2, 76(x4) skipped
abcde3b7  // lui  x7, 0xabcde
04722823  // sw   x7, 80(x4)
10030513  // addi x10, x6, 0x100
00100073  // ebreak
00000004
80000040 0000000c
80000044 00000011
80000048 00000005
80000050 abcde000
00000111

//--- flist.f
verilog/core_pkg.sv
verilog/reg_file.sv
verilog/exec_unit.sv
verilog/fetch_unit.sv
verilog/load_store_unit.sv
verilog/bus_arbiter.sv
verilog/core_top.sv
verif/core_assertions.sv
verif/tb_core.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= tb_core
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert --timescale 1ns/1ns
SIM_ARGS  ?= +verilator+error+limit+100
PASS_MSG  ?= ** PASS **

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build $(TOP) with Verilator, run it and check $(LOG)"
	@echo "  clean  remove $(OBJ_DIR) and $(LOG)"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) -f $(FLIST) --top-module $(TOP) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) $(SIM_ARGS) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -qF -- '$(PASS_MSG)' $(LOG) || (echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- verif/tb_core.sv
`timescale 1ns/1ns

module tb_core;
    import core_pkg::*;

    localparam int prog_words  = 16;
    localparam int mem_words   = 64;   // 0x8000_0000 to 0x8000_00ff
    localparam int data_words  = 32;
    localparam int max_stores  = 7;    // Pairs that still leave room for the exit code
    localparam int max_wait    = 4;    // Wait states plus the ack cycle
    localparam int margin      = 176;
    localparam int idle_cycles = 20;   // Quiet bus expected after halt
    // 16 * 7 * 2 + 176 = 400
    localparam int timeout_cycles = prog_words * (max_wait + 3) * 2 + margin;

    logic        clk;
    logic        rst;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    word_t       wb_adr;
    word_t       wb_dat_w;
    logic        wb_ack;
    word_t       wb_dat_r;
    logic        end_flag;
    word_t       exit_code;

    word_t       tdata [0:data_words-1];
    word_t       mem [0:mem_words-1];
    logic [31:0] lfsr;
    logic [1:0]  wait_left;
    logic        in_wait;
    int          exp_count;
    int          store_idx;
    int          value_errors;
    int          other_errors;
    int          cycles;

    core_top dut_i (
        .clk       (clk),
        .rst       (rst),
        .wb_ack    (wb_ack),
        .wb_dat_r  (wb_dat_r),
        .wb_cyc    (wb_cyc),
        .wb_stb    (wb_stb),
        .wb_we     (wb_we),
        .wb_adr    (wb_adr),
        .wb_dat_w  (wb_dat_w),
        .end_flag  (end_flag),
        .exit_code (exit_code)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    function automatic word_t fill_word(input word_t addr);
        return {addr[15:0], addr[31:16]} ^ 32'h3c5a_a5c3;
    endfunction

    task automatic draw_wait(output logic [1:0] w);
        lfsr = lfsr_next(lfsr);
        w[0] = lfsr[0];
        lfsr = lfsr_next(lfsr);
        w[1] = lfsr[0];
    endtask

    task automatic check_word(input string name, input word_t exp, input word_t act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR %0t %s expected %h got %h", $time, name, exp, act);
        end
    endtask

    task automatic check_flag(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            value_errors++;
            $display("ERR %0t %s expected %b got %b", $time, name, exp, act);
        end
    endtask

    task automatic record_store();
        if (store_idx >= exp_count) begin
            other_errors++;
            $display("Write of %h to %h at %0t is not in the expected list",
                     wb_dat_w, wb_adr, $time);
        end else begin
            check_word("wb_adr", tdata[17 + 2 * store_idx], wb_adr);
            check_word("wb_dat_w", tdata[18 + 2 * store_idx], wb_dat_w);
        end
        store_idx++;
    endtask

    task automatic serve_request();
        logic [5:0] idx;
        idx = wb_adr[7:2];
        if (wb_adr[31:8] != reset_pc[31:8] || wb_adr[1:0] != 2'b00) begin
            other_errors++;
            $display("Bus access to %h at %0t lies outside the memory", wb_adr, $time);
            wb_dat_r = '0;
        end else if (wb_we) begin
            record_store();
            mem[idx] = wb_dat_w;
        end else begin
            wb_dat_r = mem[idx];
        end
    endtask

    task automatic print_counts();
        $display("Errors: %0d value mismatches, %0d other failures, %0d of %0d stores seen",
                 value_errors, other_errors, store_idx, exp_count);
    endtask

    // Wishbone slave with 0 to 3 random wait states before each ack
    initial begin : memory_model
        wb_ack    = 1'b0;
        wb_dat_r  = '0;
        in_wait   = 1'b0;
        wait_left = 2'd0;
        forever begin
            @(posedge clk);
            #2;
            if (wb_ack) begin
                wb_ack = 1'b0;  // Ack lasts one cycle
            end else if (wb_cyc && wb_stb) begin
                if (!in_wait) begin
                    in_wait = 1'b1;
                    draw_wait(wait_left);
                end
                if (wait_left == 2'd0) begin
                    serve_request();
                    wb_ack  = 1'b1;
                    in_wait = 1'b0;
                end else begin
                    wait_left = wait_left - 2'd1;
                end
            end
        end
    end

    always @(posedge clk) begin
        if (!rst) begin
            cycles++;
            if (cycles >= timeout_cycles) begin
                $display("Run did not finish within %0d cycles", timeout_cycles);
                print_counts();
                $display("** FAIL **");
                $finish;
            end
        end
    end

    initial begin : main
        logic seen;
        rst          = 1'b1;
        lfsr         = 32'hf5b05792;
        store_idx    = 0;
        value_errors = 0;
        other_errors = 0;
        cycles       = 0;
        seen         = 1'b0;
        for (int i = 0; i < data_words; i++) begin
            tdata[i] = '0;
        end
        $readmemh("verif/core_testdata.hex", tdata);
        exp_count = int'(tdata[prog_words]);
        if (exp_count > max_stores) begin
            other_errors++;
            $display("Data file lists %0d stores, more than %0d fit", exp_count, max_stores);
            exp_count = max_stores;
        end
        for (int i = 0; i < mem_words; i++) begin
            mem[i] = fill_word(reset_pc + word_t'(4 * i));
        end
        for (int i = 0; i < prog_words; i++) begin
            mem[i] = tdata[i];
        end

        repeat (10) @(posedge clk);
        #2;
        check_flag("wb_cyc", 1'b0, wb_cyc);    // Idle outputs in reset
        check_flag("wb_stb", 1'b0, wb_stb);
        check_flag("wb_we", 1'b0, wb_we);
        check_flag("end_flag", 1'b0, end_flag);
        check_word("exit_code", '0, exit_code);
        rst = 1'b0;

        for (int n = 0; n < 2 && !seen; n++) begin
            @(posedge clk);
            #2;
            seen = wb_stb;
        end
        if (!seen) begin
            other_errors++;
            $display("No fetch started within 2 cycles of reset release");
        end else begin
            check_word("wb_adr", reset_pc, wb_adr);
        end

        while (!end_flag) begin
            @(posedge clk);
            #2;
        end
        check_word("exit_code", tdata[17 + 2 * exp_count], exit_code);

        repeat (idle_cycles) begin
            @(posedge clk);
            #2;
            if (wb_cyc) begin
                other_errors++;
                $display("Bus cycle open at %0t after halt", $time);
            end
            check_flag("end_flag", 1'b1, end_flag);
        end
        if (store_idx != exp_count) begin
            other_errors++;
            $display("Saw %0d stores where %0d were expected", store_idx, exp_count);
        end
        other_errors += dut_i.asrt_i.fail_count;

        print_counts();
        if (value_errors + other_errors == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- verif/core_assertions.sv
`timescale 1ns/1ns

module core_assertions (
    input logic            clk,
    input logic            rst,
    input logic            wb_cyc,
    input logic            wb_stb,
    input logic            wb_we,
    input core_pkg::word_t wb_adr,
    input core_pkg::word_t wb_dat_w,
    input logic            wb_ack,
    input logic            end_flag
);
    int fail_count = 0;  // Failed assertions so far

    stb_with_cyc: assert property (@(posedge clk) disable iff (rst) wb_stb |-> wb_cyc)
        else begin
            fail_count++;
            $error("Wishbone stb high without cyc");
        end

    // Master holds its request until ack; write data matters only on writes
    request_stable: assert property (@(posedge clk) disable iff (rst)
        (wb_stb && !wb_ack) |=> wb_stb && $stable(wb_adr) && $stable(wb_we)
                                && (!wb_we || $stable(wb_dat_w)))
        else begin
            fail_count++;
            $error("Wishbone request changed before ack");
        end

    end_flag_sticky: assert property (@(posedge clk) disable iff (rst)
        end_flag |=> end_flag)
        else begin
            fail_count++;
            $error("end_flag fell after it rose");
        end

endmodule

bind core_top core_assertions asrt_i (.*);

//--- verilog/core_top.sv
`timescale 1ns/1ns

module core_top (
    input  logic            clk,
    input  logic            rst,
    input  logic            wb_ack,
    input  core_pkg::word_t wb_dat_r,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output core_pkg::word_t wb_adr,
    output core_pkg::word_t wb_dat_w,
    output logic            end_flag,
    output core_pkg::word_t exit_code
);
    import core_pkg::*;

    // Fetch to exec
    logic  inst_valid;
    logic  inst_ready;
    word_t inst;
    word_t inst_pc;
    logic  redirect;
    word_t redirect_pc;

    // Exec to load/store
    logic  mem_req;
    logic  mem_we;
    word_t mem_addr;
    word_t mem_wdata;
    logic  mem_done;
    word_t mem_rdata;

    // Masters into the arbiter
    logic  f_cyc;
    logic  f_stb;
    word_t f_adr;
    logic  f_ack;
    word_t f_dat_r;
    logic  d_cyc;
    logic  d_stb;
    logic  d_we;
    word_t d_adr;
    word_t d_dat_w;
    logic  d_ack;
    word_t d_dat_r;

    fetch_unit fetch_i (
        .clk         (clk),
        .rst         (rst),
        .inst_ready  (inst_ready),
        .redirect    (redirect),
        .halt        (end_flag),
        .redirect_pc (redirect_pc),
        .f_ack       (f_ack),
        .f_dat_r     (f_dat_r),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .f_cyc       (f_cyc),
        .f_stb       (f_stb),
        .f_adr       (f_adr)
    );

    exec_unit exec_i (
        .clk         (clk),
        .rst         (rst),
        .inst_valid  (inst_valid),
        .inst        (inst),
        .inst_pc     (inst_pc),
        .mem_done    (mem_done),
        .mem_rdata   (mem_rdata),
        .inst_ready  (inst_ready),
        .redirect    (redirect),
        .redirect_pc (redirect_pc),
        .halt        (end_flag),      // Halt doubles as the end flag
        .mem_req     (mem_req),
        .mem_we      (mem_we),
        .mem_addr    (mem_addr),
        .mem_wdata   (mem_wdata),
        .exit_code   (exit_code)
    );

    load_store_unit lsu_i (
        .clk       (clk),
        .rst       (rst),
        .mem_req   (mem_req),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .d_ack     (d_ack),
        .d_dat_r   (d_dat_r),
        .mem_done  (mem_done),
        .mem_rdata (mem_rdata),
        .d_cyc     (d_cyc),
        .d_stb     (d_stb),
        .d_we      (d_we),
        .d_adr     (d_adr),
        .d_dat_w   (d_dat_w)
    );

    bus_arbiter arb_i (
        .clk      (clk),
        .rst      (rst),
        .f_cyc    (f_cyc),
        .f_stb    (f_stb),
        .f_adr    (f_adr),
        .f_ack    (f_ack),
        .f_dat_r  (f_dat_r),
        .d_cyc    (d_cyc),
        .d_stb    (d_stb),
        .d_we     (d_we),
        .d_adr    (d_adr),
        .d_dat_w  (d_dat_w),
        .d_ack    (d_ack),
        .d_dat_r  (d_dat_r),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_adr   (wb_adr),
        .wb_dat_w (wb_dat_w),
        .wb_ack   (wb_ack),
        .wb_dat_r (wb_dat_r)
    );

endmodule

//--- verilog/bus_arbiter.sv
`timescale 1ns/1ns

module bus_arbiter (
    input  logic            clk,
    input  logic            rst,
    input  logic            f_cyc,
    input  logic            f_stb,
    input  core_pkg::word_t f_adr,
    output logic            f_ack,
    output core_pkg::word_t f_dat_r,
    input  logic            d_cyc,
    input  logic            d_stb,
    input  logic            d_we,
    input  core_pkg::word_t d_adr,
    input  core_pkg::word_t d_dat_w,
    output logic            d_ack,
    output core_pkg::word_t d_dat_r,
    output logic            wb_cyc,
    output logic            wb_stb,
    output logic            wb_we,
    output core_pkg::word_t wb_adr,
    output core_pkg::word_t wb_dat_w,
    input  logic            wb_ack,
    input  core_pkg::word_t wb_dat_r
);
    logic locked;   // Bus was owned last cycle
    logic owner_d;  // Last owner, 1 for load/store
    logic sel_d;

    // Owner keeps the bus until it drops cyc; idle bus favors load/store
    assign sel_d = locked ? owner_d : d_cyc;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            locked  <= 1'b0;
            owner_d <= 1'b0;
        end else begin
            locked  <= wb_cyc;
            owner_d <= sel_d;
        end
    end

    assign wb_cyc   = sel_d ? d_cyc : f_cyc;
    assign wb_stb   = sel_d ? d_stb : f_stb;
    assign wb_we    = sel_d && d_we;   // Fetch side only reads
    assign wb_adr   = sel_d ? d_adr : f_adr;
    assign wb_dat_w = d_dat_w;

    // Responses go to the owner only
    assign f_ack   = !sel_d && wb_ack;
    assign d_ack   = sel_d && wb_ack;
    assign f_dat_r = sel_d ? '0 : wb_dat_r;
    assign d_dat_r = sel_d ? wb_dat_r : '0;

endmodule

//--- verilog/load_store_unit.sv
`timescale 1ns/1ns

module load_store_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            mem_req,
    input  logic            mem_we,
    input  core_pkg::word_t mem_addr,
    input  core_pkg::word_t mem_wdata,
    input  logic            d_ack,
    input  core_pkg::word_t d_dat_r,
    output logic            mem_done,
    output core_pkg::word_t mem_rdata,
    output logic            d_cyc,
    output logic            d_stb,
    output logic            d_we,
    output core_pkg::word_t d_adr,
    output core_pkg::word_t d_dat_w
);
    logic busy;  // Wishbone cycle open

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            d_we <= 1'b0;
        end else if (mem_req) begin
            busy <= 1'b1;
            d_we <= mem_we;
        end else if (d_ack) begin
            busy <= 1'b0;
        end
    end

    // Request held stable until ack
    always_ff @(posedge clk) begin
        if (mem_req) begin
            d_adr   <= mem_addr;
            d_dat_w <= mem_wdata;
        end
    end

    assign d_cyc = busy;
    assign d_stb = busy;

    assign mem_done  = busy && d_ack;
    assign mem_rdata = d_dat_r;  // Valid with mem_done

endmodule

//--- verilog/fetch_unit.sv
`timescale 1ns/1ns

module fetch_unit (
    input  logic            clk,
    input  logic            rst,
    input  logic            inst_ready,
    input  logic            redirect,
    input  logic            halt,
    input  core_pkg::word_t redirect_pc,
    input  logic            f_ack,
    input  core_pkg::word_t f_dat_r,
    output logic            inst_valid,
    output core_pkg::word_t inst,
    output core_pkg::word_t inst_pc,
    output logic            f_cyc,
    output logic            f_stb,
    output core_pkg::word_t f_adr
);
    import core_pkg::*;

    word_t  pc;        // Address of the next fetch
    logic   busy;
    logic   stale;     // In-flight fetch belongs to the old path
    logic   buf_free;
    logic   start;
    instr_u head;

    assign head = inst;

    // Buffer empty or draining now; no prefetch past a system op
    assign buf_free = !inst_valid || (inst_ready && head.i_view.opcode != op_system);
    assign start    = !busy && !halt && !redirect && buf_free;

    assign f_cyc = busy;
    assign f_stb = busy;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            pc         <= reset_pc;
            busy       <= 1'b0;
            stale      <= 1'b0;
            inst_valid <= 1'b0;
        end else begin
            if (start) begin
                busy <= 1'b1;
            end else if (f_ack) begin
                busy <= 1'b0;
            end
            if (redirect) begin
                pc    <= redirect_pc;
                stale <= busy && !f_ack;  // Let it finish, drop its data
            end else begin
                if (f_ack && !stale) begin
                    pc <= pc + 4;
                end
                if (f_ack) begin
                    stale <= 1'b0;
                end
            end
            if (redirect) begin
                inst_valid <= 1'b0;
            end else if (f_ack && !stale) begin
                inst_valid <= 1'b1;
            end else if (inst_ready) begin
                inst_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (start) begin
            f_adr <= pc;
        end
        if (f_ack && !stale && !redirect) begin
            inst    <= f_dat_r;
            inst_pc <= f_adr;
        end
    end

endmodule

//--- verilog/exec_unit.sv
`timescale 1ns/1ns

module exec_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             inst_valid,
    input  core_pkg::instr_u inst,
    input  core_pkg::word_t  inst_pc,
    input  logic             mem_done,
    input  core_pkg::word_t  mem_rdata,
    output logic             inst_ready,
    output logic             redirect,
    output core_pkg::word_t  redirect_pc,
    output logic             halt,
    output logic             mem_req,
    output logic             mem_we,
    output core_pkg::word_t  mem_addr,
    output core_pkg::word_t  mem_wdata,
    output core_pkg::word_t  exit_code
);
    import core_pkg::*;

    logic       accept;
    logic [6:0] opcode;
    logic       is_addi;
    logic       is_add;
    logic       is_lui;
    logic       is_beq;
    logic       is_load;
    logic       is_store;
    logic       is_ebreak;
    logic       taken;
    word_t      i_imm;
    word_t      s_imm;
    word_t      b_imm;
    word_t      u_imm;
    word_t      rs1_val;
    word_t      rs2_val;
    word_t      a0_val;
    word_t      alu_result;
    logic       rf_we;
    reg_idx_t   rf_rd;
    word_t      rf_wd;
    logic       mem_wait;    // Load or store on the bus
    logic       ld_pending;
    reg_idx_t   ld_rd;

    // Stall while memory is busy, a redirect is under way or after EBREAK
    assign inst_ready = !mem_wait && !redirect && !halt;
    assign accept     = inst_valid && inst_ready;

    assign opcode    = inst.i_view.opcode;
    assign is_addi   = (opcode == op_imm) && (inst.i_view.funct3 == 3'b000);
    assign is_add    = (opcode == op_reg) && (inst.i_view.funct3 == 3'b000)
                       && (inst.i_view.imm[11:5] == 7'b0);
    assign is_lui    = (opcode == op_lui);
    assign is_beq    = (opcode == op_branch) && (inst.s_view.funct3 == 3'b000);
    assign is_load   = (opcode == op_load) && (inst.i_view.funct3 == 3'b010);
    assign is_store  = (opcode == op_store) && (inst.s_view.funct3 == 3'b010);
    assign is_ebreak = (opcode == op_system) && (inst.i_view.imm == 12'h001);

    assign i_imm = {{20{inst.i_view.imm[11]}}, inst.i_view.imm};
    assign s_imm = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_hi, inst.s_view.imm_lo};
    assign b_imm = {{20{inst.s_view.imm_hi[6]}}, inst.s_view.imm_lo[0],
                    inst.s_view.imm_hi[5:0], inst.s_view.imm_lo[4:1], 1'b0};
    assign u_imm = {inst.i_view.imm, inst.i_view.rs1, inst.i_view.funct3, 12'b0};

    reg_file rf_i (
        .clk (clk),
        .rst (rst),
        .we  (rf_we),
        .rd  (rf_rd),
        .rs1 (inst.i_view.rs1),
        .rs2 (inst.s_view.rs2),
        .wd  (rf_wd),
        .rd1 (rs1_val),
        .rd2 (rs2_val),
        .a0  (a0_val)
    );

    always_comb begin
        alu_result = rs1_val + i_imm;  // ADDI by default
        if (is_add) begin
            alu_result = rs1_val + rs2_val;
        end else if (is_lui) begin
            alu_result = u_imm;
        end
    end

    assign taken = is_beq && (rs1_val == rs2_val);

    // Load data lands while the exec side is stalled, so no port clash
    assign rf_we = (accept && (is_addi || is_add || is_lui)) || (mem_done && ld_pending);
    assign rf_rd = mem_wait ? ld_rd : inst.i_view.rd;
    assign rf_wd = mem_wait ? mem_rdata : alu_result;

    assign mem_req   = accept && (is_load || is_store);
    assign mem_we    = is_store;
    assign mem_addr  = rs1_val + (is_store ? s_imm : i_imm);
    assign mem_wdata = rs2_val;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            mem_wait   <= 1'b0;
            ld_pending <= 1'b0;
            redirect   <= 1'b0;
            halt       <= 1'b0;
            exit_code  <= '0;
        end else begin
            redirect <= accept && taken;
            if (mem_req) begin
                mem_wait   <= 1'b1;
                ld_pending <= is_load;
            end else if (mem_done) begin
                mem_wait <= 1'b0;
            end
            if (accept && is_ebreak) begin
                halt      <= 1'b1;
                exit_code <= a0_val;  // a0 as seen by EBREAK
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ld_rd       <= inst.i_view.rd;
            redirect_pc <= inst_pc + b_imm;
        end
    end

endmodule

//--- verilog/reg_file.sv
`timescale 1ns/1ns

module reg_file (
    input  logic               clk,
    input  logic               rst,
    input  logic               we,
    input  core_pkg::reg_idx_t rd,
    input  core_pkg::reg_idx_t rs1,
    input  core_pkg::reg_idx_t rs2,
    input  core_pkg::word_t    wd,
    output core_pkg::word_t    rd1,
    output core_pkg::word_t    rd2,
    output core_pkg::word_t    a0
);
    import core_pkg::*;

    word_t regs [1:31];  // No storage behind x0

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we && rd != '0) begin
            regs[rd] <= wd;
        end
    end

    assign rd1 = (rs1 == '0) ? '0 : regs[rs1];
    assign rd2 = (rs2 == '0) ? '0 : regs[rs2];
    assign a0  = regs[exit_reg];

endmodule

//--- verilog/core_pkg.sv
package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_idx_t;

    localparam word_t    reset_pc = 32'h8000_0000;
    localparam reg_idx_t exit_reg = 5'd10;  // a0

    // Major opcodes of the supported subset
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_reg    = 7'b0110011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_branch = 7'b1100011;
    localparam logic [6:0] op_load   = 7'b0000011;
    localparam logic [6:0] op_store  = 7'b0100011;
    localparam logic [6:0] op_system = 7'b1110011;

    // One instruction word, read as I-type or as S/B-type
    typedef union packed {
        struct packed {
            logic [11:0] imm;     // Immediate, or funct7 over rs2
            reg_idx_t    rs1;
            logic [2:0]  funct3;
            reg_idx_t    rd;
            logic [6:0]  opcode;
        } i_view;
        struct packed {
            logic [6:0] imm_hi;
            reg_idx_t   rs2;
            reg_idx_t   rs1;
            logic [2:0] funct3;
            logic [4:0] imm_lo;
            logic [6:0] opcode;
        } s_view;
    } instr_u;

endpackage
